/* project.f */
+incdir+tb
src/cache_pkg.sv
src/cache_ifs.sv
src/tag_lookup.sv
src/miss_handler.sv
src/backing_memory.sv
src/direct_cache_top.sv
tb/tb_direct_cache.sv

/* src/backing_memory.sv */
/*
  Word-wide backing store behind the cache.
  Synchronous writes, registered reads with one cycle of latency.
  Starts out all zero.
*/

`timescale 1ns/1ps

module backing_memory import cache_pkg::*; #(
    parameter int ADDR_WIDTH = ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH = DATA_WIDTH_DEF
) (
    input  logic  clk_i,
    mem_if.slave  mem
);

    localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;
    localparam int DEPTH           = 2 ** WORD_ADDR_WIDTH;

    logic [DATA_WIDTH-1:0]      mem_array [DEPTH];
    logic [WORD_ADDR_WIDTH-1:0] word_addr;

    assign word_addr = mem.mem_addr[ADDR_WIDTH-1:OFFSET_WIDTH]; // drop byte offset

    // power-up contents
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem_array[i] = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem.mem_en) begin
            if (mem.mem_we) begin
                mem_array[word_addr] <= mem.mem_wdata;
            end else begin
                mem.mem_rdata <= mem_array[word_addr]; // holds until next read
            end
        end
    end

endmodule

/* src/cache_ifs.sv */
/*
  Bundles used inside the cache.
  miss_if carries a miss and its victim to the handler and the fill back.
  mem_if is the word bus from the handler to the backing memory.
*/

`timescale 1ns/1ps

interface miss_if import cache_pkg::*; #(
    parameter int ADDR_WIDTH  = ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH  = DATA_WIDTH_DEF,
    parameter int INDEX_WIDTH = INDEX_WIDTH_DEF
);
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    logic                  miss_valid;   // one-cycle strobe
    logic                  miss_we;
    logic [ADDR_WIDTH-1:0] miss_addr;
    logic [DATA_WIDTH-1:0] miss_wdata;
    logic                  victim_dirty;
    logic [TAG_WIDTH-1:0]  victim_tag;
    logic [DATA_WIDTH-1:0] victim_data;

    logic                  fill_valid;   // one-cycle strobe
    cache_line_t           fill_line;    // whole line for the missed index
    logic [DATA_WIDTH-1:0] fill_rdata;   // word returned to the requester

    modport lookup (
        output miss_valid, miss_we, miss_addr, miss_wdata,
        output victim_dirty, victim_tag, victim_data,
        input  fill_valid, fill_line, fill_rdata
    );

    modport handler (
        input  miss_valid, miss_we, miss_addr, miss_wdata,
        input  victim_dirty, victim_tag, victim_data,
        output fill_valid, fill_line, fill_rdata
    );
endinterface

interface mem_if #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32
);
    logic                  mem_en;
    logic                  mem_we;
    logic [ADDR_WIDTH-1:0] mem_addr;  // byte address, offset bits zero
    logic [DATA_WIDTH-1:0] mem_wdata;
    logic [DATA_WIDTH-1:0] mem_rdata; // valid one cycle after a read

    modport master (output mem_en, mem_we, mem_addr, mem_wdata, input mem_rdata);
    modport slave  (input mem_en, mem_we, mem_addr, mem_wdata, output mem_rdata);
endinterface

/* src/cache_pkg.sv */
/*
  Shared definitions for the direct-mapped write-back cache.
  Default widths, the stored line layout and the miss handler states.
  Modules pull these in with a wildcard import in their header.
*/

package cache_pkg;

    // default geometry, overridden per module through parameters
    localparam int ADDR_WIDTH_DEF  = 16; // byte address
    localparam int DATA_WIDTH_DEF  = 32; // one word per line
    localparam int INDEX_WIDTH_DEF = 3;  // 8 lines

    // low address bits select a byte inside the word and are ignored
    localparam int OFFSET_WIDTH = 2;

    // tag is whatever is left above index and offset
    localparam int TAG_WIDTH_DEF = ADDR_WIDTH_DEF - INDEX_WIDTH_DEF - OFFSET_WIDTH;

    // one stored cache line
    typedef struct packed {
        logic                      valid;
        logic                      dirty; // differs from backing memory
        logic [TAG_WIDTH_DEF-1:0]  tag;
        logic [DATA_WIDTH_DEF-1:0] data;
    } cache_line_t;

    // miss handler sequence
    typedef enum logic [2:0] {
        IDLE,       // waiting for a miss
        WB_WRITE,   // dirty victim goes back to memory
        FILL_READ,  // read enable for the missed word
        FILL_WAIT,  // memory word arrives
        FILL_WRITE  // new line handed to the lookup stage
    } miss_state_t;

endpackage

/* src/direct_cache_top.sv */
/*
  Top level of the direct-mapped write-back cache with its backing memory.
  Requests use a valid/ready pair, responses are a one-cycle strobe.
*/

`timescale 1ns/1ps

module direct_cache_top import cache_pkg::*; #(
    parameter int ADDR_WIDTH  = ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH  = DATA_WIDTH_DEF,
    parameter int INDEX_WIDTH = INDEX_WIDTH_DEF
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  logic                  req_we_i,
    input  logic [ADDR_WIDTH-1:0] req_addr_i,
    input  logic [DATA_WIDTH-1:0] req_wdata_i,

    output logic                  resp_valid_o,
    output logic [DATA_WIDTH-1:0] resp_rdata_o,
    output logic                  resp_hit_o
);

    miss_if #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .DATA_WIDTH  (DATA_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) miss_bus ();

    mem_if #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) mem_bus ();

    tag_lookup #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .DATA_WIDTH  (DATA_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_tag_lookup (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_we_i     (req_we_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .resp_hit_o   (resp_hit_o),
        .miss         (miss_bus.lookup)
    );

    miss_handler #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .DATA_WIDTH  (DATA_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_miss_handler (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .miss    (miss_bus.handler),
        .mem     (mem_bus.master)
    );

    backing_memory #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_backing_memory (
        .clk_i (clk_i),
        .mem   (mem_bus.slave)
    );

endmodule

/* src/miss_handler.sv */
/*
  Second pipeline stage of the cache.
  Writes a dirty victim back, reads the missed word and builds the new line.
  The finished line goes back to the lookup stage with a one-cycle fill strobe.
*/

`timescale 1ns/1ps

module miss_handler import cache_pkg::*; #(
    parameter int ADDR_WIDTH  = ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH  = DATA_WIDTH_DEF,
    parameter int INDEX_WIDTH = INDEX_WIDTH_DEF
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    miss_if.handler  miss,
    mem_if.master    mem
);

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    miss_state_t state_q;
    miss_state_t state_d;

    // request and victim, captured when the miss arrives
    logic                  we_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [TAG_WIDTH-1:0]  vtag_q;
    logic [DATA_WIDTH-1:0] vdata_q;
    logic [DATA_WIDTH-1:0] rdata_q; // word read from memory

    logic [INDEX_WIDTH-1:0] index;
    logic [TAG_WIDTH-1:0]   req_tag;
    logic [ADDR_WIDTH-1:0]  wb_addr;
    logic [ADDR_WIDTH-1:0]  fill_addr;
    cache_line_t            new_line;

    assign index   = addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_tag = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];

    // victim address rebuilt from its tag and the shared index
    assign wb_addr   = {vtag_q, index, {OFFSET_WIDTH{1'b0}}};
    assign fill_addr = {req_tag, index, {OFFSET_WIDTH{1'b0}}};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (miss.miss_valid) begin
                    state_d = miss.victim_dirty ? WB_WRITE : FILL_READ;
                end
            end
            WB_WRITE:   state_d = FILL_READ;
            FILL_READ:  state_d = FILL_WAIT;
            FILL_WAIT:  state_d = FILL_WRITE;
            FILL_WRITE: state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    // payload capture
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && miss.miss_valid) begin
            we_q    <= miss.miss_we;
            addr_q  <= miss.miss_addr;
            wdata_q <= miss.miss_wdata;
            vtag_q  <= miss.victim_tag;
            vdata_q <= miss.victim_data;
        end

        if (state_q == FILL_WAIT) begin
            rdata_q <= mem.mem_rdata; // arrives one cycle after FILL_READ
        end
    end

    // memory bus, one access per state
    assign mem.mem_en    = (state_q == WB_WRITE) || (state_q == FILL_READ);
    assign mem.mem_we    = (state_q == WB_WRITE);
    assign mem.mem_addr  = (state_q == WB_WRITE) ? wb_addr : fill_addr;
    assign mem.mem_wdata = vdata_q;

    // write miss installs the new word dirty, read miss installs memory clean
    always_comb begin
        new_line.valid = 1'b1;
        new_line.dirty = we_q;
        new_line.tag   = req_tag;
        new_line.data  = we_q ? wdata_q : rdata_q;
    end

    assign miss.fill_valid = (state_q == FILL_WRITE);
    assign miss.fill_line  = new_line;
    assign miss.fill_rdata = new_line.data;

endmodule

/* src/tag_lookup.sv */
/*
  First pipeline stage of the cache.
  Holds the line array, checks tags and answers hits one cycle after acceptance.
  Misses go to the handler; the stage stalls until the fill arrives.
*/

`timescale 1ns/1ps

module tag_lookup import cache_pkg::*; #(
    parameter int ADDR_WIDTH  = ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH  = DATA_WIDTH_DEF,
    parameter int INDEX_WIDTH = INDEX_WIDTH_DEF
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  logic                  req_we_i,
    input  logic [ADDR_WIDTH-1:0] req_addr_i,
    input  logic [DATA_WIDTH-1:0] req_wdata_i,

    output logic                  resp_valid_o,
    output logic [DATA_WIDTH-1:0] resp_rdata_o,
    output logic                  resp_hit_o,

    miss_if.lookup                miss
);

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int NUM_LINES = 2 ** INDEX_WIDTH;

    cache_line_t lines [NUM_LINES];

    logic [INDEX_WIDTH-1:0] req_index;
    logic [TAG_WIDTH-1:0]   req_tag;
    logic [INDEX_WIDTH-1:0] fill_index;
    cache_line_t            cur_line;
    logic                   hit;
    logic                   accept;
    logic                   pending_q; // set while a miss is outstanding

    assign req_index = req_addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_tag   = req_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign cur_line  = lines[req_index];

    assign hit = cur_line.valid && (cur_line.tag == req_tag);

    // low through the fill cycle so a fill never meets a new lookup
    assign req_ready_o = !pending_q;
    assign accept      = req_valid_i && req_ready_o;

    // miss_addr is held until the fill, so it still names the right line
    assign fill_index = miss.miss_addr[OFFSET_WIDTH +: INDEX_WIDTH];

    // control and strobes
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q       <= 1'b0;
            resp_valid_o    <= 1'b0;
            resp_hit_o      <= 1'b0;
            miss.miss_valid <= 1'b0;
        end else begin
            resp_valid_o    <= 1'b0;
            miss.miss_valid <= 1'b0;

            if (accept) begin
                if (hit) begin
                    resp_valid_o <= 1'b1;
                    resp_hit_o   <= 1'b1;
                end else begin
                    miss.miss_valid <= 1'b1; // hand off to handler
                    pending_q       <= 1'b1;
                end
            end

            if (miss.fill_valid) begin
                pending_q    <= 1'b0;
                resp_valid_o <= 1'b1;
                resp_hit_o   <= 1'b0;
            end
        end
    end

    // response word and miss payload
    always_ff @(posedge clk_i) begin
        if (accept && hit) begin
            resp_rdata_o <= req_we_i ? req_wdata_i : cur_line.data; // writes echo the word
        end

        if (accept && !hit) begin
            miss.miss_we      <= req_we_i;
            miss.miss_addr    <= req_addr_i;
            miss.miss_wdata   <= req_wdata_i;
            miss.victim_dirty <= cur_line.valid && cur_line.dirty;
            miss.victim_tag   <= cur_line.tag;
            miss.victim_data  <= cur_line.data;
        end

        if (miss.fill_valid) begin
            resp_rdata_o <= miss.fill_rdata;
        end
    end

    // line array
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else if (accept && hit && req_we_i) begin
            lines[req_index].data  <= req_wdata_i;
            lines[req_index].dirty <= 1'b1; // now differs from memory
        end else if (miss.fill_valid) begin
            lines[fill_index] <= miss.fill_line;
        end
    end

endmodule

/* tb/cache_ref_model.svh */
/*
  Reference model of the cache, included inside the testbench module.
  The shadow memory keeps the last word written to each word address.
  The shadow tables keep the tag and valid state per index to predict hits.
*/

`ifndef CACHE_REF_MODEL_SVH
`define CACHE_REF_MODEL_SVH

localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
localparam int NUM_LINES = 2 ** INDEX_WIDTH;
localparam int NUM_WORDS = 2 ** (ADDR_WIDTH - OFFSET_WIDTH);

logic [DATA_WIDTH-1:0] shadow_mem   [NUM_WORDS];
logic [TAG_WIDTH-1:0]  shadow_tag   [NUM_LINES];
logic                  shadow_valid [NUM_LINES];

function automatic void model_reset();
    for (int i = 0; i < NUM_WORDS; i++) begin
        shadow_mem[i] = '0; // memory powers up zero
    end
    for (int i = 0; i < NUM_LINES; i++) begin
        shadow_valid[i] = 1'b0;
        shadow_tag[i]   = '0;
    end
endfunction

// predicts the response word and hit flag and then updates the shadow state
function automatic void model_access(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                                     input logic [DATA_WIDTH-1:0] wdata,
                                     output logic [DATA_WIDTH-1:0] rdata, output logic hit);
    int unsigned          idx;
    int unsigned          word;
    logic [TAG_WIDTH-1:0] tag;
    idx  = addr[OFFSET_WIDTH +: INDEX_WIDTH];
    word = addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    tag  = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    hit  = shadow_valid[idx] && (shadow_tag[idx] == tag);
    if (we) begin
        shadow_mem[word] = wdata;
    end
    rdata = shadow_mem[word]; // writes echo the word just written
    if (!hit) begin
        shadow_valid[idx] = 1'b1; // every miss installs the line
        shadow_tag[idx]   = tag;
    end
endfunction

`endif

/* tb/tb_direct_cache.sv */
/*
  Testbench for the direct-mapped cache top level.
  Drives requests on the falling edge and checks every response against
  the reference model with assertions, then prints a summary.
*/

`timescale 1ns/1ps

module tb_direct_cache import cache_pkg::*;;

    localparam int ADDR_WIDTH     = ADDR_WIDTH_DEF;
    localparam int DATA_WIDTH     = DATA_WIDTH_DEF;
    localparam int INDEX_WIDTH    = INDEX_WIDTH_DEF;
    localparam int TIMEOUT_CYCLES = 50;

    `include "cache_ref_model.svh"

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  req_valid_i;
    logic                  req_ready_o;
    logic                  req_we_i;
    logic [ADDR_WIDTH-1:0] req_addr_i;
    logic [DATA_WIDTH-1:0] req_wdata_i;
    logic                  resp_valid_o;
    logic [DATA_WIDTH-1:0] resp_rdata_o;
    logic                  resp_hit_o;

    logic [DATA_WIDTH-1:0] exp_rdata_q [$]; // expected responses in order
    logic                  exp_hit_q   [$];
    logic [ADDR_WIDTH-1:0] exp_addr_q  [$];
    int                    errors;
    int                    checks;
    int                    tests;
    int                    test_errors_base;
    int                    stall_cycles; // ready wait of the last request
    integer                seed;
    event                  timeout_ev;

    direct_cache_top #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .DATA_WIDTH  (DATA_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) dut_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_we_i     (req_we_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .resp_hit_o   (resp_hit_o)
    );

    always #20 clk_i = ~clk_i; // 40 ns period

    initial begin : timeout_report
        @(timeout_ev);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic report_timeout(input string what);
        miss_state_t hstate;
        hstate = dut_i.u_miss_handler.state_q;
        $display("Timeout while waiting for %s, miss handler in state %s", what, hstate.name());
        -> timeout_ev;
        @(posedge clk_i); // run ends in the report process
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue_request(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                                 input logic [DATA_WIDTH-1:0] wdata);
        int                    cycles;
        logic [DATA_WIDTH-1:0] exp_data;
        logic                  exp_hit;
        cycles      = 0;
        req_valid_i = 1'b0;
        while (req_ready_o !== 1'b1) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("req_ready_o");
            end
        end
        stall_cycles = cycles;
        req_valid_i  = 1'b1;
        req_we_i     = we;
        req_addr_i   = addr;
        req_wdata_i  = wdata;
        model_access(we, addr, wdata, exp_data, exp_hit);
        exp_rdata_q.push_back(exp_data);
        exp_hit_q.push_back(exp_hit);
        exp_addr_q.push_back(addr);
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    task automatic wait_responses();
        int cycles;
        cycles = 0;
        while (exp_rdata_q.size() != 0) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("resp_valid_o");
            end
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errors - test_errors_base);
        test_errors_base = errors;
    endtask

    // outputs change on the rising edge and are sampled on the falling one
    always @(negedge clk_i) begin : response_check
        logic [DATA_WIDTH-1:0] exp_data;
        logic                  exp_hit;
        logic [ADDR_WIDTH-1:0] exp_addr;
        if (rst_n_i === 1'b1 && resp_valid_o === 1'b1) begin
            if (exp_rdata_q.size() == 0) begin
                $display("A response arrived with no request outstanding");
                errors++;
            end else begin
                exp_data = exp_rdata_q.pop_front();
                exp_hit  = exp_hit_q.pop_front();
                exp_addr = exp_addr_q.pop_front();
                checks  += 2;
                assert (resp_rdata_o === exp_data) else begin
                    $display("Fail resp_rdata_o at addr 0x%h: got 0x%h, expected 0x%h",
                             exp_addr, resp_rdata_o, exp_data);
                    errors++;
                end
                assert (resp_hit_o === exp_hit) else begin
                    $display("Fail resp_hit_o at addr 0x%h: got 0x%h, expected 0x%h",
                             exp_addr, resp_hit_o, exp_hit);
                    errors++;
                end
            end
        end
    end

    initial begin
        logic [31:0]           rnd;
        logic [ADDR_WIDTH-1:0] addr;
        int                    stalls;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_we_i    = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_errors_base = 0;
        stall_cycles     = 0;
        seed        = 32;
        model_reset();
        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;

        checks += 2;
        assert (req_ready_o === 1'b1) else begin
            $display("Fail req_ready_o after reset: got 0x%h, expected 0x1", req_ready_o);
            errors++;
        end
        assert (resp_valid_o === 1'b0) else begin
            $display("Fail resp_valid_o after reset: got 0x%h, expected 0x0", resp_valid_o);
            errors++;
        end

        // fresh lines miss with zero and hit on the second pass
        for (int pass = 0; pass < 2; pass++) begin
            issue_request(1'b0, 16'h0000, '0);
            issue_request(1'b0, 16'h0024, '0);
            issue_request(1'b0, 16'h1018, '0);
        end
        wait_responses();
        report_test("fresh reads");

        issue_request(1'b1, 16'h0048, 32'hcafe_0001); // write miss
        issue_request(1'b0, 16'h0048, '0);
        wait_responses();
        report_test("write then read");

        // A and B share an index, so A must come back from memory
        issue_request(1'b1, 16'h020c, 32'h1234_abcd);
        issue_request(1'b0, 16'h060c, '0);
        issue_request(1'b0, 16'h020c, '0);
        wait_responses();
        report_test("dirty eviction");

        // push both words to memory first and then alternate clean misses
        issue_request(1'b1, 16'h0010, 32'h0c0c_0c0c);
        issue_request(1'b1, 16'h0810, 32'h0d0d_0d0d);
        issue_request(1'b0, 16'h1010, '0);
        for (int k = 0; k < 3; k++) begin
            issue_request(1'b0, 16'h0010, '0);
            issue_request(1'b0, 16'h0810, '0);
        end
        wait_responses();
        report_test("clean eviction");

        issue_request(1'b1, 16'h0014, 32'h5555_aaaa);
        wait_responses();
        stalls = 0;
        for (int k = 0; k < 6; k++) begin
            issue_request(k == 3, 16'h0014, 32'h5a5a_0000 + k);
            stalls += stall_cycles;
        end
        assert (stalls == 0) else begin
            $display("Hit requests were not accepted on consecutive cycles");
            errors++;
        end
        wait_responses();
        report_test("back-to-back hits");

        for (int n = 0; n < 200; n++) begin
            rnd  = $random(seed);
            addr = rnd[ADDR_WIDTH-1:0] & 16'h00fc; // 64 words over 8 lines
            rnd  = $random(seed);
            issue_request(rnd[0], addr, $random(seed));
        end
        wait_responses();
        report_test("random mix");

        $display("tests run %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
